// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --timescale 1ns/100ps -f sources.f \
    --top-module id_stage_tb -o id_stage_sim > build.log 2>&1 \
    || { echo "verilator build failed, see build.log"; exit 1; }

./obj_dir/id_stage_sim > sim.log 2>&1 \
    || { cat sim.log; echo "simulation exited with an error"; exit 1; }

cat sim.log
grep -q "Some tests failed" sim.log && { echo "result: FAIL"; exit 1; } \
    || { echo "result: PASS"; exit 0; }

// ==== source/branch_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module branch_unit (
    input  logic [31:0]  pc,
    input  logic [31:0]  rj_value,
    input  logic [31:0]  rkd_value,
    input  id_pkg::dec_t dec,
    output logic         taken,
    output logic [31:0]  target
);
    import id_pkg::*;

    logic [31:0] offs;
    logic        eq;
    logic        lt;
    logic        ltu;

    always_comb begin
        eq  = (rj_value == rkd_value);
        lt  = ($signed(rj_value) < $signed(rkd_value));
        ltu = (rj_value < rkd_value);

        if (dec.br_kind == BR_B || dec.br_kind == BR_BL) begin
            offs = {{4{dec.offs26[25]}}, dec.offs26, 2'b00};
        end else begin
            offs = {{14{dec.offs26[15]}}, dec.offs26[15:0], 2'b00};
        end

        case (dec.br_kind)
            BR_B, BR_BL, BR_JIRL: taken = 1'b1;
            BR_BEQ:  taken = eq;
            BR_BNE:  taken = !eq;
            BR_BLT:  taken = lt;
            BR_BGE:  taken = !lt;
            BR_BLTU: taken = ltu;
            BR_BGEU: taken = !ltu;
            default: taken = 1'b0;
        endcase

        target = ((dec.br_kind == BR_JIRL) ? rj_value : pc) + offs;
    end

endmodule

`default_nettype wire

// ==== source/id_pkg.sv ====
`default_nettype none

package id_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_NOR,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_NONE,
        BR_B,
        BR_BL,
        BR_JIRL,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU
    } br_kind_e;

    // major opcode, inst[31:26]
    localparam logic [5:0] OP6_ALU       = 6'h00;
    localparam logic [5:0] OP6_LU12I     = 6'h05; // inst[25] must be 0
    localparam logic [5:0] OP6_PCADDU12I = 6'h07;
    localparam logic [5:0] OP6_MEM       = 6'h0a;
    localparam logic [5:0] OP6_JIRL      = 6'h13;
    localparam logic [5:0] OP6_B         = 6'h14;
    localparam logic [5:0] OP6_BL        = 6'h15;
    localparam logic [5:0] OP6_BEQ       = 6'h16;
    localparam logic [5:0] OP6_BNE       = 6'h17;
    localparam logic [5:0] OP6_BLT       = 6'h18;
    localparam logic [5:0] OP6_BGE       = 6'h19;
    localparam logic [5:0] OP6_BLTU      = 6'h1a;
    localparam logic [5:0] OP6_BGEU      = 6'h1b;

    // inst[25:22]
    localparam logic [3:0] OP4_3R    = 4'h0;
    localparam logic [3:0] OP4_SHIFT = 4'h1;
    localparam logic [3:0] OP4_LD_W  = 4'h2;
    localparam logic [3:0] OP4_ST_W  = 4'h6;
    localparam logic [3:0] OP4_SLTI  = 4'h8;
    localparam logic [3:0] OP4_SLTUI = 4'h9;
    localparam logic [3:0] OP4_ADDI  = 4'ha;
    localparam logic [3:0] OP4_ANDI  = 4'hd;
    localparam logic [3:0] OP4_ORI   = 4'he;
    localparam logic [3:0] OP4_XORI  = 4'hf;

    // inst[21:20] for the 3R and shift groups
    localparam logic [1:0] OP2_3R    = 2'h1;
    localparam logic [1:0] OP2_SHIFT = 2'h0;

    // inst[19:15]
    localparam logic [4:0] OP5_ADD    = 5'h00;
    localparam logic [4:0] OP5_SUB    = 5'h02;
    localparam logic [4:0] OP5_SLT    = 5'h04;
    localparam logic [4:0] OP5_SLTU   = 5'h05;
    localparam logic [4:0] OP5_NOR    = 5'h08;
    localparam logic [4:0] OP5_AND    = 5'h09;
    localparam logic [4:0] OP5_OR     = 5'h0a;
    localparam logic [4:0] OP5_XOR    = 5'h0b;
    localparam logic [4:0] OP5_SLL    = 5'h0e;
    localparam logic [4:0] OP5_SRL    = 5'h0f;
    localparam logic [4:0] OP5_SRA    = 5'h10;
    localparam logic [4:0] OP5_SLLI_W = 5'h01;
    localparam logic [4:0] OP5_SRLI_W = 5'h09;
    localparam logic [4:0] OP5_SRAI_W = 5'h11;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
    } if_id_t;

    typedef struct packed {
        alu_op_e     alu_op;
        logic [31:0] src1;
        logic [31:0] src2;
        logic [31:0] rkd_value;  // store data
        logic [4:0]  dest;
        logic        gr_we;
        logic        mem_we;
        logic        res_from_mem;
        logic [31:0] pc;
    } id_ex_t;

    typedef struct packed {
        logic        valid;
        logic [4:0]  dest;
        logic [31:0] wdata;
    } fwd_t;

    typedef struct packed {
        logic        taken;
        logic [31:0] target;
    } br_t;

    typedef struct packed {
        alu_op_e     alu_op;
        logic [4:0]  rj;
        logic [4:0]  rk_or_rd;
        logic        use_rj;
        logic        use_r2;
        logic        src1_is_pc;
        logic        src2_is_imm;
        logic [31:0] imm;
        logic [4:0]  dest;
        logic        gr_we;
        logic        mem_we;
        logic        res_from_mem;
        br_kind_e    br_kind;
        logic [25:0] offs26;     // {inst[9:0], inst[25:10]}, low 16 bits are offs16
    } dec_t;

endpackage

`default_nettype wire

// ==== source/id_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module id_stage (
    input  logic           clk,
    input  logic           resetn,
    input  logic           if_id_valid,
    input  id_pkg::if_id_t if_id,
    output logic           id_allowin,
    input  logic           exe_allowin,
    output logic           id_exe_valid,
    output id_pkg::id_ex_t id_ex,
    input  id_pkg::fwd_t   exe_fwd,
    input  id_pkg::fwd_t   mem_fwd,
    input  id_pkg::fwd_t   wb_fwd,
    input  logic           exe_is_load,
    output id_pkg::br_t    br
);
    import id_pkg::*;

    logic        id_valid;
    if_id_t      id_q;      // stage register
    dec_t        dec;
    logic [31:0] rf_rdata1;
    logic [31:0] rf_rdata2;
    logic [31:0] rj_value;
    logic [31:0] rkd_value;
    logic        stall;
    logic        ready_go;
    logic        taken;
    logic [31:0] target;

    assign ready_go     = !stall;
    assign id_exe_valid = id_valid && ready_go;
    assign id_allowin   = !id_valid || (ready_go && exe_allowin);

    // redirect only once the branch actually leaves
    assign br.taken  = taken && id_exe_valid && exe_allowin;
    assign br.target = target;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            id_valid <= 1'b0;
        end else if (br.taken) begin
            id_valid <= 1'b0;  // drop the wrong-path fetch
        end else if (id_allowin) begin
            id_valid <= if_id_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (if_id_valid && id_allowin) begin
            id_q <= if_id;
        end
    end

    inst_decoder u_dec (
        .inst (id_q.inst),
        .dec  (dec)
    );

    regfile u_rf (
        .clk    (clk),
        .raddr1 (dec.rj),
        .raddr2 (dec.rk_or_rd),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .wr     (wb_fwd)
    );

    operand_bypass u_byp (
        .dec         (dec),
        .rdata1      (rf_rdata1),
        .rdata2      (rf_rdata2),
        .exe_fwd     (exe_fwd),
        .mem_fwd     (mem_fwd),
        .wb_fwd      (wb_fwd),
        .exe_is_load (exe_is_load),
        .rj_value    (rj_value),
        .rkd_value   (rkd_value),
        .stall       (stall)
    );

    branch_unit u_br (
        .pc        (id_q.pc),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .dec       (dec),
        .taken     (taken),
        .target    (target)
    );

    always_comb begin
        id_ex.alu_op       = dec.alu_op;
        id_ex.src1         = dec.src1_is_pc ? id_q.pc : rj_value;
        id_ex.src2         = dec.src2_is_imm ? dec.imm : rkd_value;
        id_ex.rkd_value    = rkd_value;
        id_ex.dest         = dec.dest;
        id_ex.gr_we        = dec.gr_we;
        id_ex.mem_we       = dec.mem_we;
        id_ex.res_from_mem = dec.res_from_mem;
        id_ex.pc           = id_q.pc;
    end

    // a stalled instruction is not issued and is still there next cycle
    stall_holds: assert property (
        @(posedge clk) disable iff (!resetn)
        (id_valid && stall) |-> !id_exe_valid ##1 (id_valid && $stable(id_q))
    ) else $error("id_stage: stalled instruction issued or lost");

endmodule

`default_nettype wire

// ==== source/inst_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module inst_decoder (
    input  logic [31:0]  inst,
    output id_pkg::dec_t dec
);
    import id_pkg::*;

    logic [5:0]  op6;
    logic [3:0]  op4;
    logic [1:0]  op2;
    logic [4:0]  op5;
    logic [4:0]  rd;
    logic [4:0]  rj;
    logic [4:0]  rk;
    logic [11:0] i12;
    logic [19:0] i20;
    logic        known;

    assign op6 = inst[31:26];
    assign op4 = inst[25:22];
    assign op2 = inst[21:20];
    assign op5 = inst[19:15];
    assign rd  = inst[4:0];
    assign rj  = inst[9:5];
    assign rk  = inst[14:10];
    assign i12 = inst[21:10];
    assign i20 = inst[24:5];

    always_comb begin
        known        = 1'b1;
        dec          = '0;
        dec.alu_op   = ALU_ADD;
        dec.br_kind  = BR_NONE;
        dec.rj       = rj;
        dec.rk_or_rd = rk;
        dec.dest     = rd;
        dec.offs26   = {inst[9:0], inst[25:10]};
        dec.imm      = {{20{i12[11]}}, i12};
        case (op6)
            OP6_ALU: begin
                dec.use_rj = 1'b1;
                dec.gr_we  = 1'b1;
                if (op4 == OP4_3R && op2 == OP2_3R) begin
                    dec.use_r2 = 1'b1;
                    case (op5)
                        OP5_ADD:  dec.alu_op = ALU_ADD;
                        OP5_SUB:  dec.alu_op = ALU_SUB;
                        OP5_SLT:  dec.alu_op = ALU_SLT;
                        OP5_SLTU: dec.alu_op = ALU_SLTU;
                        OP5_NOR:  dec.alu_op = ALU_NOR;
                        OP5_AND:  dec.alu_op = ALU_AND;
                        OP5_OR:   dec.alu_op = ALU_OR;
                        OP5_XOR:  dec.alu_op = ALU_XOR;
                        OP5_SLL:  dec.alu_op = ALU_SLL;
                        OP5_SRL:  dec.alu_op = ALU_SRL;
                        OP5_SRA:  dec.alu_op = ALU_SRA;
                        default:  known = 1'b0;
                    endcase
                end else if (op4 == OP4_SHIFT && op2 == OP2_SHIFT) begin
                    dec.src2_is_imm = 1'b1;  // ui5 sits in imm[4:0]
                    case (op5)
                        OP5_SLLI_W: dec.alu_op = ALU_SLL;
                        OP5_SRLI_W: dec.alu_op = ALU_SRL;
                        OP5_SRAI_W: dec.alu_op = ALU_SRA;
                        default:    known = 1'b0;
                    endcase
                end else begin
                    dec.src2_is_imm = 1'b1;
                    case (op4)
                        OP4_SLTI:  dec.alu_op = ALU_SLT;
                        OP4_SLTUI: dec.alu_op = ALU_SLTU;
                        OP4_ADDI:  dec.alu_op = ALU_ADD;
                        OP4_ANDI:  dec.alu_op = ALU_AND;
                        OP4_ORI:   dec.alu_op = ALU_OR;
                        OP4_XORI:  dec.alu_op = ALU_XOR;
                        default:   known = 1'b0;
                    endcase
                    if (op4 == OP4_ANDI || op4 == OP4_ORI || op4 == OP4_XORI) begin
                        dec.imm = {20'd0, i12};  // logical ops zero-extend
                    end
                end
            end
            OP6_LU12I, OP6_PCADDU12I: begin
                known           = ~inst[25];
                dec.gr_we       = 1'b1;
                dec.src2_is_imm = 1'b1;
                dec.imm         = {i20, 12'd0};
                dec.src1_is_pc  = (op6 == OP6_PCADDU12I);
                dec.alu_op      = (op6 == OP6_LU12I) ? ALU_LUI : ALU_ADD;
            end
            OP6_MEM: begin
                dec.use_rj      = 1'b1;
                dec.src2_is_imm = 1'b1;
                if (op4 == OP4_LD_W) begin
                    dec.gr_we        = 1'b1;
                    dec.res_from_mem = 1'b1;
                end else if (op4 == OP4_ST_W) begin
                    dec.mem_we   = 1'b1;
                    dec.use_r2   = 1'b1;
                    dec.rk_or_rd = rd;  // store data comes from rd
                end else begin
                    known = 1'b0;
                end
            end
            OP6_JIRL, OP6_BL: begin
                dec.gr_we       = 1'b1;
                dec.src1_is_pc  = 1'b1;
                dec.src2_is_imm = 1'b1;
                dec.imm         = 32'd4;  // link value pc + 4
                dec.use_rj      = (op6 == OP6_JIRL);
                dec.br_kind     = (op6 == OP6_JIRL) ? BR_JIRL : BR_BL;
                if (op6 == OP6_BL) begin
                    dec.dest = 5'd1;
                end
            end
            OP6_B: dec.br_kind = BR_B;
            OP6_BEQ, OP6_BNE, OP6_BLT, OP6_BGE, OP6_BLTU, OP6_BGEU: begin
                dec.use_rj   = 1'b1;
                dec.use_r2   = 1'b1;
                dec.rk_or_rd = rd;
                case (op6)
                    OP6_BEQ:  dec.br_kind = BR_BEQ;
                    OP6_BNE:  dec.br_kind = BR_BNE;
                    OP6_BLT:  dec.br_kind = BR_BLT;
                    OP6_BGE:  dec.br_kind = BR_BGE;
                    OP6_BLTU: dec.br_kind = BR_BLTU;
                    default:  dec.br_kind = BR_BGEU;
                endcase
            end
            default: known = 1'b0;
        endcase

        // anything outside the subset becomes a no-op
        if (!known) begin
            dec.alu_op       = ALU_ADD;
            dec.gr_we        = 1'b0;
            dec.mem_we       = 1'b0;
            dec.res_from_mem = 1'b0;
            dec.use_rj       = 1'b0;
            dec.use_r2       = 1'b0;
            dec.src1_is_pc   = 1'b0;
            dec.src2_is_imm  = 1'b0;
            dec.br_kind      = BR_NONE;
        end
    end

endmodule

`default_nettype wire

// ==== source/operand_bypass.sv ====
`timescale 1ns/100ps
`default_nettype none

module operand_bypass (
    input  id_pkg::dec_t dec,
    input  logic [31:0]  rdata1,
    input  logic [31:0]  rdata2,
    input  id_pkg::fwd_t exe_fwd,
    input  id_pkg::fwd_t mem_fwd,
    input  id_pkg::fwd_t wb_fwd,
    input  logic         exe_is_load,
    output logic [31:0]  rj_value,
    output logic [31:0]  rkd_value,
    output logic         stall
);
    import id_pkg::*;

    // later stage holds a pending write to a used source
    function automatic logic hit(
        input fwd_t       f,
        input logic [4:0] addr,
        input logic       used
    );
        return f.valid && (f.dest == addr) && (addr != 5'd0) && used;
    endfunction

    function automatic logic [31:0] pick(
        input logic [4:0]  addr,
        input logic        used,
        input logic [31:0] rf_val,
        input fwd_t        e,
        input fwd_t        m,
        input fwd_t        w
    );
        logic [31:0] v;
        if (hit(e, addr, used)) begin
            v = e.wdata;  // youngest wins
        end else if (hit(m, addr, used)) begin
            v = m.wdata;
        end else if (hit(w, addr, used)) begin
            v = w.wdata;
        end else begin
            v = rf_val;
        end
        return v;
    endfunction

    assign rj_value  = pick(dec.rj, dec.use_rj, rdata1, exe_fwd, mem_fwd, wb_fwd);
    assign rkd_value = pick(dec.rk_or_rd, dec.use_r2, rdata2, exe_fwd, mem_fwd, wb_fwd);

    // load data not ready until mem, so wait one cycle
    assign stall = exe_is_load
                && (hit(exe_fwd, dec.rj, dec.use_rj) || hit(exe_fwd, dec.rk_or_rd, dec.use_r2));

endmodule

`default_nettype wire

// ==== source/regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

module regfile (
    input  logic         clk,
    input  logic [4:0]   raddr1,
    input  logic [4:0]   raddr2,
    output logic [31:0]  rdata1,
    output logic [31:0]  rdata2,
    input  id_pkg::fwd_t wr
);

    logic [31:0] rf [32];
    logic        we;

    assign we = wr.valid && (wr.dest != 5'd0);

    always_ff @(posedge clk) begin
        if (we) begin
            rf[wr.dest] <= wr.wdata;
        end
    end

    // r0 is hardwired, its array entry is never written
    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : rf[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : rf[raddr2];

    // a writeback aimed at r0 leaves the entry untouched
    r0_never_written: assert property (
        @(posedge clk) (wr.valid && wr.dest == 5'd0) |=> (rf[0] === $past(rf[0]))
    ) else $error("regfile: r0 entry changed by a writeback to r0");

endmodule

`default_nettype wire

// ==== sources.f ====
source/id_pkg.sv
source/inst_decoder.sv
source/regfile.sv
source/operand_bypass.sv
source/branch_unit.sv
source/id_stage.sv
tests/id_clock_gen.sv
tests/id_stage_tb.sv

// ==== tests/id_clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module id_clock_gen (
    output logic clk,
    output logic resetn
);

    initial begin
        clk    = 1'b0;
        resetn = 1'b0;
        repeat (2) @(posedge clk);
        #1 resetn = 1'b1;  // released just after the second edge
    end

    always #10 clk = ~clk;  // 20 ns period

endmodule

`default_nettype wire

// ==== tests/id_stage_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module id_stage_tb;
    import id_pkg::*;

    // instruction kinds, 0..10 three-register, 11..13 shifts, 14..19 reg-imm12
    localparam int K_LU   = 20;
    localparam int K_PCA  = 21;
    localparam int K_LD   = 22;
    localparam int K_ST   = 23;
    localparam int K_JIRL = 24;
    localparam int K_B    = 25;
    localparam int K_BL   = 26;
    localparam int K_BCC  = 27;  // beq..bgeu

    localparam logic [4:0] OP5_TABLE [14] = '{OP5_ADD, OP5_SUB, OP5_SLT, OP5_SLTU, OP5_NOR,
        OP5_AND, OP5_OR, OP5_XOR, OP5_SLL, OP5_SRL, OP5_SRA, OP5_SLLI_W, OP5_SRLI_W, OP5_SRAI_W};
    localparam alu_op_e ALU_TABLE [20] = '{ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_NOR,
        ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_SLT, ALU_SLTU, ALU_ADD, ALU_AND, ALU_OR, ALU_XOR};
    localparam logic [3:0] OP4_TABLE [6] = '{OP4_SLTI, OP4_SLTUI, OP4_ADDI, OP4_ANDI,
        OP4_ORI, OP4_XORI};
    localparam logic [5:0] OP6_BCC [6] = '{OP6_BEQ, OP6_BNE, OP6_BLT, OP6_BGE, OP6_BLTU, OP6_BGEU};
    localparam br_kind_e BK_TABLE [6] = '{BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU};

    typedef struct packed {
        alu_op_e     op;
        logic        use_rj;
        logic        use_r2;
        logic        pc_src1;
        logic        imm_src2;
        logic [31:0] imm;
        logic [4:0]  r2;
        logic [4:0]  dest;
        logic        gr_we;
        logic        mem_we;
        logic        load;
        br_kind_e    bk;
    } ref_dec_t;

    logic        clk;
    logic        resetn;
    logic        if_id_valid;
    if_id_t      if_id;
    logic        id_allowin;
    logic        exe_allowin;
    logic        id_exe_valid;
    id_ex_t      id_ex;
    fwd_t        exe_fwd;
    fwd_t        mem_fwd;
    fwd_t        wb_fwd;
    logic        exe_is_load;
    br_t         br;
    logic [31:0] rf_model [32];
    int          errors;
    int          passed;
    int          failed;

    id_clock_gen u_clk (
        .clk    (clk),
        .resetn (resetn)
    );

    id_stage DUT (
        .clk          (clk),
        .resetn       (resetn),
        .if_id_valid  (if_id_valid),
        .if_id        (if_id),
        .id_allowin   (id_allowin),
        .exe_allowin  (exe_allowin),
        .id_exe_valid (id_exe_valid),
        .id_ex        (id_ex),
        .exe_fwd      (exe_fwd),
        .mem_fwd      (mem_fwd),
        .wb_fwd       (wb_fwd),
        .exe_is_load  (exe_is_load),
        .br           (br)
    );

    always @(posedge clk) begin
        if (wb_fwd.valid && wb_fwd.dest != 5'd0) begin
            rf_model[wb_fwd.dest] <= wb_fwd.wdata;
        end
    end

    task automatic check(input bit cond, input string msg);
        assert (cond) else begin
            $display("[FAIL] %0t ns: %s", $time, msg);
            errors++;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic fwd_t make_fwd(input logic v, input logic [4:0] d, input logic [31:0] x);
        fwd_t f;
        f.valid = v;
        f.dest  = d;
        f.wdata = x;
        return f;
    endfunction

    function automatic fwd_t random_fwd();
        return make_fwd(1'($urandom), 5'($urandom % 4), $urandom);
    endfunction

    function automatic logic [31:0] random_pc();
        logic [31:0] r;
        r = $urandom;
        return {r[31:2], 2'b00};
    endfunction

    function automatic logic [31:0] make_inst(input int k, input logic [31:0] r);
        if (k < 11) return {OP6_ALU, OP4_3R, OP2_3R, OP5_TABLE[4'(k)], r[14:0]};
        if (k < 14) return {OP6_ALU, OP4_SHIFT, OP2_SHIFT, OP5_TABLE[4'(k)], r[14:0]};
        if (k < 20) return {OP6_ALU, OP4_TABLE[3'(k - 14)], r[21:0]};
        if (k == K_LU) return {OP6_LU12I, 1'b0, r[24:0]};
        if (k == K_PCA) return {OP6_PCADDU12I, 1'b0, r[24:0]};
        if (k == K_LD) return {OP6_MEM, OP4_LD_W, r[21:0]};
        if (k == K_ST) return {OP6_MEM, OP4_ST_W, r[21:0]};
        if (k == K_JIRL) return {OP6_JIRL, r[25:0]};
        if (k == K_B) return {OP6_B, r[25:0]};
        if (k == K_BL) return {OP6_BL, r[25:0]};
        return {OP6_BCC[3'(k - K_BCC)], r[25:0]};
    endfunction

    function automatic ref_dec_t ref_decode(input int k, input logic [31:0] inst);
        ref_dec_t d;
        d      = '0;
        d.op   = ALU_ADD;
        d.bk   = BR_NONE;
        d.r2   = inst[14:10];
        d.dest = inst[4:0];
        d.imm  = {{20{inst[21]}}, inst[21:10]};
        if (k < 20) begin
            d.op       = ALU_TABLE[5'(k)];
            d.use_rj   = 1'b1;
            d.gr_we    = 1'b1;
            d.use_r2   = (k < 11);
            d.imm_src2 = (k >= 11);
            if (k >= 17) d.imm = {20'd0, inst[21:10]};  // andi, ori, xori
        end else if (k <= K_PCA) begin
            d.op       = (k == K_LU) ? ALU_LUI : ALU_ADD;
            d.gr_we    = 1'b1;
            d.imm_src2 = 1'b1;
            d.pc_src1  = (k == K_PCA);
            d.imm      = {inst[24:5], 12'd0};
        end else if (k <= K_ST) begin
            d.use_rj   = 1'b1;
            d.imm_src2 = 1'b1;
            d.gr_we    = (k == K_LD);
            d.load     = (k == K_LD);
            d.mem_we   = (k == K_ST);
            d.use_r2   = (k == K_ST);
            if (k == K_ST) d.r2 = inst[4:0];
        end else if (k == K_JIRL || k == K_BL) begin
            d.gr_we    = 1'b1;
            d.pc_src1  = 1'b1;
            d.imm_src2 = 1'b1;
            d.imm      = 32'd4;
            d.use_rj   = (k == K_JIRL);
            d.bk       = (k == K_JIRL) ? BR_JIRL : BR_BL;
            if (k == K_BL) d.dest = 5'd1;
        end else if (k == K_B) begin
            d.bk = BR_B;
        end else begin
            d.use_rj = 1'b1;
            d.use_r2 = 1'b1;
            d.r2     = inst[4:0];
            d.bk     = BK_TABLE[3'(k - K_BCC)];
        end
        return d;
    endfunction

    // youngest pending write first, then the register file
    function automatic logic [31:0] operand(input logic [4:0] a, input logic used);
        if (a == 5'd0) return 32'd0;
        if (used && exe_fwd.valid && exe_fwd.dest == a) return exe_fwd.wdata;
        if (used && mem_fwd.valid && mem_fwd.dest == a) return mem_fwd.wdata;
        if (used && wb_fwd.valid && wb_fwd.dest == a) return wb_fwd.wdata;
        return rf_model[a];
    endfunction

    task automatic check_decode(input int k, input logic [31:0] pc, input logic [31:0] inst);
        ref_dec_t    d;
        id_ex_t      want;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] offs;
        logic [31:0] tgt;
        logic        tk;
        d = ref_decode(k, inst);
        a = operand(inst[9:5], d.use_rj);
        b = operand(d.r2, d.use_r2);
        want.alu_op       = d.op;
        want.src1         = d.pc_src1 ? pc : a;
        want.src2         = d.imm_src2 ? d.imm : b;
        want.rkd_value    = b;
        want.dest         = d.dest;
        want.gr_we        = d.gr_we;
        want.mem_we       = d.mem_we;
        want.res_from_mem = d.load;
        want.pc           = pc;
        check(id_ex === want, $sformatf("kind %0d inst %h: id_ex %h, expected %h",
            k, inst, id_ex, want));
        case (d.bk)
            BR_NONE: tk = 1'b0;
            BR_BEQ:  tk = (a == b);
            BR_BNE:  tk = (a != b);
            BR_BLT:  tk = ($signed(a) < $signed(b));
            BR_BGE:  tk = ($signed(a) >= $signed(b));
            BR_BLTU: tk = (a < b);
            BR_BGEU: tk = (a >= b);
            default: tk = 1'b1;
        endcase
        check(br.taken === (tk && exe_allowin), $sformatf("inst %h: br.taken %b, expected %b",
            inst, br.taken, tk && exe_allowin));
        if (d.bk != BR_NONE) begin
            offs = (d.bk == BR_B || d.bk == BR_BL) ? {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00}
                                                  : {{14{inst[25]}}, inst[25:10], 2'b00};
            tgt  = ((d.bk == BR_JIRL) ? a : pc) + offs;
            check(br.target === tgt, $sformatf("inst %h pc %h: target %h, expected %h",
                inst, pc, br.target, tgt));
        end
    endtask

    task automatic present(input logic [31:0] pc, input logic [31:0] inst, input fwd_t e,
                           input fwd_t m, input fwd_t w, input logic ld, input logic allow);
        if_id_valid = 1'b1;
        if_id.pc    = pc;
        if_id.inst  = inst;
        exe_fwd     = e;
        mem_fwd     = m;
        wb_fwd      = w;
        exe_is_load = ld;
        exe_allowin = allow;
    endtask

    task automatic wait_for_issue(input int limit, output bit ok);
        int n;
        n = 0;
        @(negedge clk);
        while (!id_exe_valid && n < limit) begin
            @(negedge clk);
            n++;
        end
        ok = id_exe_valid;
        if (!ok) begin
            $display("timeout: no instruction left decode within %0d cycles", limit);
            errors++;
        end
    endtask

    task automatic run_one(input int k, input logic [31:0] inst, input logic [31:0] pc,
                           input fwd_t e, input fwd_t m, input fwd_t w, input logic allow);
        bit ok;
        next_cycle();
        present(pc, inst, e, m, w, 1'b0, allow);
        next_cycle();
        if_id_valid = 1'b0;  // accepted on that edge
        wait_for_issue(8, ok);
        if (ok) check_decode(k, pc, inst);
    endtask

    task automatic end_test(input string name, input int errs_at_start);
        if (errors == errs_at_start) begin
            $display("test %s: ok", name);
            passed++;
        end else begin
            $display("test %s: %0d check(s) wrong", name, errors - errs_at_start);
            failed++;
        end
    endtask

    initial begin
        int          k;
        int          n;
        int          e0;
        logic [31:0] r;
        logic [31:0] pc;
        logic [31:0] inst;
        logic [4:0]  d;
        id_ex_t      held;
        bit          ok;
        errors = 0;
        passed = 0;
        failed = 0;
        void'($urandom(32'h0bded45a));
        if_id_valid = 1'b0;
        if_id       = '0;
        exe_allowin = 1'b1;
        exe_fwd     = '0;
        mem_fwd     = '0;
        wb_fwd      = '0;
        exe_is_load = 1'b0;

        e0 = errors;
        n  = 0;
        @(negedge clk);
        while (!resetn && n < 10) begin
            check(!id_exe_valid && !br.taken && id_allowin, "stage not empty during reset");
            @(negedge clk);
            n++;
        end
        if (!resetn) begin
            $display("timeout: reset never released");
            errors++;
        end
        check(!id_exe_valid && !br.taken && id_allowin, "stage not empty after reset");
        end_test("reset", e0);

        // fill the register file through writeback
        for (int i = 1; i < 32; i++) begin
            next_cycle();
            wb_fwd = make_fwd(1'b1, 5'(i), $urandom);
        end
        next_cycle();
        wb_fwd = '0;

        e0 = errors;
        for (int i = 0; i < 60; i++) begin
            k = int'($urandom % 22);
            run_one(k, make_inst(k, $urandom), random_pc(), '0, '0, '0, 1'b1);
        end
        end_test("alu decode", e0);

        e0 = errors;
        for (int i = 0; i < 60; i++) begin
            k = int'($urandom % 12);
            if (k == 11) k = K_ST;
            r        = $urandom;
            r[4:0]   = 5'($urandom % 4);  // few registers, many collisions
            r[9:5]   = 5'($urandom % 4);
            r[14:10] = 5'($urandom % 4);
            run_one(k, make_inst(k, r), random_pc(), random_fwd(), random_fwd(), random_fwd(), 1'b1);
        end
        end_test("forwarding", e0);

        e0 = errors;
        for (int i = 0; i < 10; i++) begin
            k = int'($urandom % 11);
            d = 5'(1 + $urandom % 31);
            r = $urandom;
            if (i % 2 == 0) r[9:5] = d;
            else r[14:10] = d;
            inst = make_inst(k, r);
            pc   = random_pc();
            next_cycle();
            present(pc, inst, make_fwd(1'b1, d, $urandom), '0, '0, 1'b1, 1'b1);
            next_cycle();
            if_id_valid = 1'b0;
            repeat (3) begin
                @(negedge clk);
                check(!id_exe_valid && !id_allowin, "load-use hazard did not hold the stage");
            end
            next_cycle();
            exe_is_load = 1'b0;  // load data now forwardable
            wait_for_issue(8, ok);
            if (ok) check_decode(k, pc, inst);
        end
        end_test("load-use stall", e0);

        e0 = errors;
        for (int i = 0; i < 60; i++) begin
            k = K_JIRL + int'($urandom % 9);
            r = $urandom;
            if ($urandom % 3 == 0) r[4:0] = r[9:5];  // equal operands
            run_one(k, make_inst(k, r), random_pc(), random_fwd(), '0, '0, 1'b1);
        end
        for (int i = 0; i < 5; i++) begin
            pc = random_pc();
            next_cycle();
            present(pc, make_inst(K_B, $urandom), '0, '0, '0, 1'b0, 1'b1);
            next_cycle();
            if_id.pc   = pc + 4;  // wrong path, still valid
            if_id.inst = make_inst(int'($urandom % 11), $urandom);
            @(negedge clk);
            check(br.taken === 1'b1, "b gave no redirect strobe");
            next_cycle();
            if_id_valid = 1'b0;
            repeat (3) begin
                @(negedge clk);
                check(!id_exe_valid, "wrong-path instruction issued after a taken branch");
            end
        end
        end_test("branches", e0);

        e0 = errors;
        for (int i = 0; i < 10; i++) begin
            k = (i % 2 == 0) ? K_LD : K_ST;
            run_one(k, make_inst(k, $urandom), random_pc(), '0, '0, '0, 1'b0);
            held = id_ex;
            repeat (3) begin
                @(negedge clk);
                check(id_exe_valid && !id_allowin && id_ex === held,
                    "id_ex changed or fetch accepted under back-pressure");
            end
            next_cycle();
            exe_allowin = 1'b1;
        end
        end_test("back-pressure", e0);

        $display("tests: %0d ok, %0d wrong, %0d failing checks", passed, failed, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        #1000000;
        $display("simulation ran far too long and was stopped");
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire
